// ==== hw/pwm_reg_pkg.sv ====
package pwm_reg_pkg;

  localparam int pwm_num    = 4;
  localparam int dwidth     = 8;
  localparam int awidth     = 6;
  localparam int chan_idx_w = $clog2(pwm_num);

  typedef logic [dwidth-1:0]     data_t;
  typedef logic [pwm_num-1:0]    chan_mask_t;
  typedef logic [awidth-2:0]     slot_t;
  typedef logic [chan_idx_w-1:0] chan_idx_t;

  // register map
  localparam logic [awidth-1:0] addr_prescale    = 6'd0;
  localparam logic [awidth-1:0] addr_period      = 6'd1;
  localparam logic [awidth-1:0] addr_enable      = 6'd2;
  localparam logic [awidth-1:0] addr_enable_hi   = 6'd3;
  localparam logic [awidth-1:0] addr_chan_base   = 6'd4;
  localparam logic [awidth-1:0] addr_sync_update = 6'd57;

  // each channel owns one slot of two words, rising edge first
  localparam slot_t chan_slot_base = slot_t'(addr_chan_base >> 1);
  localparam slot_t chan_slot_cnt  = slot_t'(pwm_num);

  localparam data_t reset_prescale = 8'd8;
  localparam data_t reset_period   = 8'd8;

  // channels 0 and 2 shadowed, 1 and 3 follow the staged values
  localparam chan_mask_t shadow_reg_en = 4'b0101;

  typedef struct packed {
    slot_t slot;
    logic  edge_sel;
  } pwm_chan_addr_t;

  // fixed registers decode the raw word, edge registers the channel view
  typedef union packed {
    logic [awidth-1:0] raw;
    pwm_chan_addr_t    chan;
  } pwm_addr_u;

  typedef struct packed {
    data_t               prescale;
    data_t               period;
    chan_mask_t          enable;
    data_t [pwm_num-1:0] pos_edge;
    data_t [pwm_num-1:0] neg_edge;
  } pwm_cfg_t;

  // slots below the base wrap to large offsets and fall out of range
  function automatic logic is_chan_addr(pwm_addr_u a);
    slot_t off;
    off = a.chan.slot - chan_slot_base;
    return off < chan_slot_cnt;
  endfunction

  function automatic chan_idx_t chan_of(pwm_addr_u a);
    slot_t off;
    off = a.chan.slot - chan_slot_base;
    return off[chan_idx_w-1:0];
  endfunction

endpackage

// ==== hw/pwm_stage_regs.sv ====
`timescale 1ns/100ps

module pwm_stage_regs (
  input  logic                   PCLK,
  input  logic                   PRESETN,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  pwm_reg_pkg::pwm_addr_u paddr,
  input  pwm_reg_pkg::data_t     pwdata,
  output pwm_reg_pkg::pwm_cfg_t  staged,
  output logic                   sync_update
);

  import pwm_reg_pkg::*;

  logic       wr_en;
  logic       wr_prescale;
  logic       wr_period;
  logic       wr_enable;
  logic       wr_sync;
  chan_mask_t wr_pos;
  chan_mask_t wr_neg;

  // access phase of an APB write
  assign wr_en = psel && penable && pwrite;

  always_comb
  begin
    wr_prescale = wr_en && (paddr.raw == addr_prescale);
    wr_period   = wr_en && (paddr.raw == addr_period);
    wr_enable   = wr_en && (paddr.raw == addr_enable);
    wr_sync     = wr_en && (paddr.raw == addr_sync_update);
    wr_pos      = '0;
    wr_neg      = '0;
    if (wr_en && is_chan_addr(paddr))
    begin
      if (paddr.chan.edge_sel)
        wr_neg[chan_of(paddr)] = 1'b1;
      else
        wr_pos[chan_of(paddr)] = 1'b1;
    end
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      staged.prescale <= reset_prescale;
      staged.period   <= reset_period;
      staged.enable   <= '0;
      sync_update     <= 1'b0;
    end
    else
    begin
      if (wr_prescale)
        staged.prescale <= pwdata;
      if (wr_period)
        staged.period <= pwdata;
      // upper data bits have no channel behind them
      if (wr_enable)
        staged.enable <= pwdata[pwm_num-1:0];
      if (wr_sync)
        sync_update <= pwdata[0];
    end
  end

  // per-channel edge words
  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      staged.pos_edge <= '0;
      staged.neg_edge <= '0;
    end
    else
    begin
      for (int k = 0; k < pwm_num; k++)
      begin
        if (wr_pos[k])
          staged.pos_edge[k] <= pwdata;
        if (wr_neg[k])
          staged.neg_edge[k] <= pwdata;
      end
    end
  end

  // access phase only follows a selected setup phase
  a_penable_needs_psel: assert property (
    @(posedge PCLK) disable iff (!PRESETN)
    penable |-> psel
  );

endmodule

// ==== hw/pwm_shadow_regs.sv ====
`timescale 1ns/100ps

module pwm_shadow_regs (
  input  logic                  PCLK,
  input  logic                  PRESETN,
  input  pwm_reg_pkg::pwm_cfg_t staged,
  input  logic                  sync_update,
  input  pwm_reg_pkg::data_t    period_cnt,
  input  logic                  sync_pulse,
  output pwm_reg_pkg::pwm_cfg_t active
);

  import pwm_reg_pkg::*;

  pwm_cfg_t shadow;
  logic     period_end;
  logic     edge_load;

  // end of period measured against the period currently in use
  assign period_end = sync_pulse && (period_cnt >= shadow.period);
  assign edge_load  = period_end && sync_update;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETN)
    begin
      shadow.prescale <= reset_prescale;
      shadow.period   <= reset_period;
      shadow.enable   <= '0;
      shadow.pos_edge <= '0;
      shadow.neg_edge <= '0;
    end
    else
    begin
      if (period_end)
      begin
        shadow.prescale <= staged.prescale;
        shadow.period   <= staged.period;
        shadow.enable   <= staged.enable;
      end
      // edges wait for the sync flag as well
      if (edge_load)
      begin
        shadow.pos_edge <= staged.pos_edge;
        shadow.neg_edge <= staged.neg_edge;
      end
    end
  end

  // prescale and period are shared by all channels so always shadowed
  always_comb
  begin
    active.prescale = shadow.prescale;
    active.period   = shadow.period;
    for (int k = 0; k < pwm_num; k++)
    begin
      if (shadow_reg_en[k])
      begin
        active.enable[k]   = shadow.enable[k];
        active.pos_edge[k] = shadow.pos_edge[k];
        active.neg_edge[k] = shadow.neg_edge[k];
      end
      else
      begin
        active.enable[k]   = staged.enable[k];
        active.pos_edge[k] = staged.pos_edge[k];
        active.neg_edge[k] = staged.neg_edge[k];
      end
    end
  end

  for (genvar k = 0; k < pwm_num; k++)
  begin : g_edge_hold
    if (shadow_reg_en[k])
    begin : g_shadowed
      a_edge_stable: assert property (
        @(posedge PCLK) disable iff (!PRESETN)
        !period_end |=> $stable(active.pos_edge[k]) && $stable(active.neg_edge[k])
      );
    end
  end

endmodule

// ==== hw/pwm_read_mux.sv ====
`timescale 1ns/100ps

module pwm_read_mux (
  input  pwm_reg_pkg::pwm_addr_u paddr,
  input  pwm_reg_pkg::pwm_cfg_t  active,
  input  logic                   sync_update,
  output pwm_reg_pkg::data_t     prdata
);

  import pwm_reg_pkg::*;

  logic      chan_hit;
  chan_idx_t chan_idx;
  data_t     edge_word;
  data_t     enable_word;

  assign chan_hit = is_chan_addr(paddr);
  assign chan_idx = chan_of(paddr);

  // one indexed pick covers every channel slot
  always_comb
  begin
    if (paddr.chan.edge_sel)
      edge_word = active.neg_edge[chan_idx];
    else
      edge_word = active.pos_edge[chan_idx];
  end

  assign enable_word = {{(dwidth - pwm_num){1'b0}}, active.enable};

  always_comb
  begin
    case (paddr.raw)
      addr_prescale:
        prdata = active.prescale;
      addr_period:
        prdata = active.period;
      addr_enable:
        prdata = enable_word;
      // four channels fit in the low enable word
      addr_enable_hi:
        prdata = '0;
      addr_sync_update:
        prdata = {{(dwidth - 1){1'b0}}, sync_update};
      default:
      begin
        if (chan_hit)
          prdata = edge_word;
        else
          prdata = '0;
      end
    endcase
  end

endmodule

// ==== hw/pwm_reg_if.sv ====
`timescale 1ns/100ps

module pwm_reg_if (
  input  logic                   PCLK,
  input  logic                   PRESETN,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  pwm_reg_pkg::pwm_addr_u paddr,
  input  pwm_reg_pkg::data_t     pwdata,
  input  pwm_reg_pkg::data_t     period_cnt,
  input  logic                   sync_pulse,
  output pwm_reg_pkg::data_t     prdata,
  output pwm_reg_pkg::pwm_cfg_t  cfg
);

  import pwm_reg_pkg::*;

  pwm_cfg_t staged;
  logic     sync_update;

  pwm_stage_regs u_stage (
    .PCLK        (PCLK),
    .PRESETN     (PRESETN),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .staged      (staged),
    .sync_update (sync_update)
  );

  pwm_shadow_regs u_shadow (
    .PCLK        (PCLK),
    .PRESETN     (PRESETN),
    .staged      (staged),
    .sync_update (sync_update),
    .period_cnt  (period_cnt),
    .sync_pulse  (sync_pulse),
    .active      (cfg)
  );

  pwm_read_mux u_read (
    .paddr       (paddr),
    .active      (cfg),
    .sync_update (sync_update),
    .prdata      (prdata)
  );

endmodule

// ==== testbench/pwm_reg_checker.sv ====
`timescale 1ns/100ps

module pwm_reg_checker (
  input  logic                  PCLK,
  input  logic                  check_en,
  input  logic                  done,
  input  string                 name,
  input  pwm_reg_pkg::data_t    exp_prdata,
  input  pwm_reg_pkg::pwm_cfg_t exp_cfg,
  input  pwm_reg_pkg::data_t    prdata,
  input  pwm_reg_pkg::pwm_cfg_t cfg,
  output int                    pass_cnt,
  output int                    fail_cnt
);

  int n_pass = 0;
  int n_fail = 0;

  assign pass_cnt = n_pass;
  assign fail_cnt = n_fail;

  // stimulus settles 1 ns after the previous edge, so both sides are stable here
  always @(posedge PCLK)
  begin
    if (check_en)
    begin
      if (prdata !== exp_prdata)
      begin
        n_fail = n_fail + 1;
        $display("FAILED %s: prdata expected %h actual %h", name, exp_prdata, prdata);
      end
      else if (cfg !== exp_cfg)
      begin
        n_fail = n_fail + 1;
        $display("FAILED %s: cfg expected %h actual %h", name, exp_cfg, cfg);
      end
      else
      begin
        n_pass = n_pass + 1;
        $display("ok     %s: prdata %h", name, prdata);
      end
    end
    if (done)
      $display("checks done: %0d passed, %0d failed", n_pass, n_fail);
  end

endmodule

// ==== testbench/tb_pwm_reg_if.sv ====
`timescale 1ns/100ps

module tb_pwm_reg_if;

  import pwm_reg_pkg::*;

  typedef enum logic [1:0] {k_idle, k_write, k_read, k_pulse} step_kind_t;

  typedef struct packed {
    step_kind_t        kind;
    logic [awidth-1:0] addr;
    data_t             data;
    data_t             cnt;
    logic              check;
  } step_t;

  logic      PCLK;
  logic      PRESETN;
  logic      psel;
  logic      penable;
  logic      pwrite;
  pwm_addr_u paddr;
  data_t     pwdata;
  data_t     period_cnt;
  logic      sync_pulse;
  data_t     prdata;
  pwm_cfg_t  cfg;

  logic     check_en;
  logic     done;
  string    cur_name;
  data_t    exp_prdata;
  pwm_cfg_t exp_cfg;
  int       pass_cnt;
  int       fail_cnt;

  step_t       steps[$];
  string       step_name[$];
  logic        table_ready;
  logic [31:0] lcg_state;

  // reference model of the staged set, the shadow copies and the sync flag
  pwm_cfg_t stg;
  pwm_cfg_t shd;
  logic     stg_sync;

  pwm_reg_if pwm_reg_if_i (
    .PCLK       (PCLK),
    .PRESETN    (PRESETN),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .period_cnt (period_cnt),
    .sync_pulse (sync_pulse),
    .prdata     (prdata),
    .cfg        (cfg)
  );

  pwm_reg_checker u_checker (
    .PCLK       (PCLK),
    .check_en   (check_en),
    .done       (done),
    .name       (cur_name),
    .exp_prdata (exp_prdata),
    .exp_cfg    (exp_cfg),
    .prdata     (prdata),
    .cfg        (cfg),
    .pass_cnt   (pass_cnt),
    .fail_cnt   (fail_cnt)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #4 PCLK = ~PCLK;
  end

  function automatic data_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic model_reset();
    stg          = '0;
    stg.prescale = 8'd8;
    stg.period   = 8'd8;
    shd          = stg;
    stg_sync     = 1'b0;
  endtask

  task automatic model_write(input logic [awidth-1:0] addr, input data_t d);
    logic [awidth-1:0] off;
    off = addr - 6'd4;
    case (addr)
      6'd0:
        stg.prescale = d;
      6'd1:
        stg.period = d;
      6'd2:
        stg.enable = d[3:0];
      6'd57:
        stg_sync = d[0];
      default:
      begin
        // two words per channel from address 4, odd word is the falling edge
        if (off < 6'd8 && addr[0])
          stg.neg_edge[off[2:1]] = d;
        else if (off < 6'd8)
          stg.pos_edge[off[2:1]] = d;
      end
    endcase
  endtask

  task automatic model_pulse(input data_t cnt);
    if (cnt >= shd.period)
    begin
      shd.prescale = stg.prescale;
      shd.period   = stg.period;
      shd.enable   = stg.enable;
      if (stg_sync)
      begin
        shd.pos_edge = stg.pos_edge;
        shd.neg_edge = stg.neg_edge;
      end
    end
  endtask

  function automatic pwm_cfg_t model_cfg();
    pwm_cfg_t    c;
    logic [31:0] keep;
    keep = {{8{shadow_reg_en[3]}}, {8{shadow_reg_en[2]}},
            {8{shadow_reg_en[1]}}, {8{shadow_reg_en[0]}}};
    c          = shd;
    c.enable   = (shd.enable & shadow_reg_en) | (stg.enable & ~shadow_reg_en);
    c.pos_edge = (shd.pos_edge & keep) | (stg.pos_edge & ~keep);
    c.neg_edge = (shd.neg_edge & keep) | (stg.neg_edge & ~keep);
    return c;
  endfunction

  function automatic data_t model_read(input logic [awidth-1:0] addr);
    pwm_cfg_t          c;
    logic [awidth-1:0] off;
    data_t             r;
    c   = model_cfg();
    off = addr - 6'd4;
    r   = 8'd0;
    if (addr == 6'd0)
      r = c.prescale;
    else if (addr == 6'd1)
      r = c.period;
    else if (addr == 6'd2)
      r = {4'b0, c.enable};
    else if (addr == 6'd57)
      r = {7'b0, stg_sync};
    else if (off < 6'd8 && addr[0])
      r = c.neg_edge[off[2:1]];
    else if (off < 6'd8)
      r = c.pos_edge[off[2:1]];
    return r;
  endfunction

  task automatic apb_write(input logic [awidth-1:0] addr, input data_t d);
    psel      = 1'b1;
    pwrite    = 1'b1;
    paddr.raw = addr;
    pwdata    = d;
    @(posedge PCLK);
    #1;
    penable = 1'b1;
    @(posedge PCLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // one cycle with the expected values shown to the checker
  task automatic compare_cycle(input logic [awidth-1:0] addr, input string name,
                               input logic rd);
    paddr.raw  = addr;
    psel       = rd;
    penable    = rd;
    cur_name   = name;
    exp_prdata = model_read(addr);
    exp_cfg    = model_cfg();
    check_en   = 1'b1;
    @(posedge PCLK);
    #1;
    check_en = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
  endtask

  task automatic apply_step(input int i);
    step_t s;
    data_t d;
    s = steps[i];
    d = s.data;
    case (s.kind)
      k_write:
      begin
        if (s.addr >= 6'd4 && s.addr < 6'd12)
          d = lcg_next();
        apb_write(s.addr, d);
        model_write(s.addr, d);
      end
      k_read:
      begin
        psel      = 1'b1;
        paddr.raw = s.addr;
        @(posedge PCLK);
        #1;
      end
      k_pulse:
      begin
        sync_pulse = 1'b1;
        period_cnt = s.cnt;
        @(posedge PCLK);
        #1;
        sync_pulse = 1'b0;
        period_cnt = 8'd0;
        model_pulse(s.cnt);
      end
      default:
      begin
        @(posedge PCLK);
        #1;
      end
    endcase
    if (s.check || s.kind == k_read)
      compare_cycle(s.addr, step_name[i], s.kind == k_read);
  endtask

  task automatic add_step(input string name, input step_kind_t kind,
                          input logic [awidth-1:0] addr, input data_t data,
                          input data_t cnt, input logic check);
    step_t s;
    s.kind  = kind;
    s.addr  = addr;
    s.data  = data;
    s.cnt   = cnt;
    s.check = check;
    steps.push_back(s);
    step_name.push_back(name);
  endtask

  task automatic build_table();
    for (int a = 0; a < 12; a++)
    begin
      if (a != 3)
        add_step($sformatf("reset_read_%0d", a), k_read, 6'(a), 8'h00, 8'h00, 1'b1);
    end
    add_step("reset_sync", k_read, 6'd57, 8'h00, 8'h00, 1'b1);
    // channels 1 and 3 follow their writes at once
    add_step("direct_enable", k_write, 6'd2, 8'h0a, 8'h00, 1'b1);
    add_step("direct_ch1_rise", k_write, 6'd6, 8'h00, 8'h00, 1'b1);
    add_step("direct_ch1_fall", k_write, 6'd7, 8'h00, 8'h00, 1'b1);
    add_step("direct_ch3_rise", k_write, 6'd10, 8'h00, 8'h00, 1'b1);
    add_step("direct_ch3_fall", k_write, 6'd11, 8'h00, 8'h00, 1'b1);
    add_step("shadow_prescale_wr", k_write, 6'd0, 8'h20, 8'h00, 1'b1);
    add_step("shadow_period_wr", k_write, 6'd1, 8'h10, 8'h00, 1'b1);
    add_step("shadow_ch0_rise_wr", k_write, 6'd4, 8'h00, 8'h00, 1'b1);
    add_step("shadow_ch0_fall_wr", k_write, 6'd5, 8'h00, 8'h00, 1'b1);
    add_step("shadow_enable_wr", k_write, 6'd2, 8'h0f, 8'h00, 1'b1);
    add_step("sync_set", k_write, 6'd57, 8'h01, 8'h00, 1'b1);
    add_step("pulse_below_period", k_pulse, 6'd0, 8'h00, 8'h07, 1'b1);
    add_step("pulse_at_period", k_pulse, 6'd0, 8'h00, 8'h08, 1'b1);
    add_step("shadow_period_rd", k_read, 6'd1, 8'h00, 8'h00, 1'b1);
    add_step("shadow_enable_rd", k_read, 6'd2, 8'h00, 8'h00, 1'b1);
    add_step("shadow_ch0_rise_rd", k_read, 6'd4, 8'h00, 8'h00, 1'b1);
    add_step("shadow_ch0_fall_rd", k_read, 6'd5, 8'h00, 8'h00, 1'b1);
    // with the sync flag clear the shadowed edges must hold
    add_step("sync_clear", k_write, 6'd57, 8'h00, 8'h00, 1'b1);
    add_step("hold_ch2_rise_wr", k_write, 6'd8, 8'h00, 8'h00, 1'b1);
    add_step("hold_ch2_fall_wr", k_write, 6'd9, 8'h00, 8'h00, 1'b1);
    add_step("hold_prescale_wr", k_write, 6'd0, 8'h30, 8'h00, 1'b0);
    add_step("hold_period_wr", k_write, 6'd1, 8'h0c, 8'h00, 1'b0);
    // shadowed enable bits flip so the load is visible
    add_step("hold_enable_wr", k_write, 6'd2, 8'h0a, 8'h00, 1'b0);
    add_step("pulse_no_sync", k_pulse, 6'd8, 8'h00, 8'h20, 1'b1);
    add_step("hold_prescale_rd", k_read, 6'd0, 8'h00, 8'h00, 1'b1);
    add_step("hold_period_rd", k_read, 6'd1, 8'h00, 8'h00, 1'b1);
    add_step("hold_enable_rd", k_read, 6'd2, 8'h00, 8'h00, 1'b1);
    add_step("hold_ch2_fall_rd", k_read, 6'd9, 8'h00, 8'h00, 1'b1);
    add_step("enable_hi_wr", k_write, 6'd3, 8'hff, 8'h00, 1'b1);
    add_step("unused_wr", k_write, 6'd40, 8'h5a, 8'h00, 1'b1);
    add_step("past_chan_rise_rd", k_read, 6'd12, 8'h00, 8'h00, 1'b1);
    add_step("past_chan_fall_rd", k_read, 6'd13, 8'h00, 8'h00, 1'b1);
    add_step("top_addr_rd", k_read, 6'd63, 8'h00, 8'h00, 1'b1);
    add_step("sync_bit0_clear", k_write, 6'd57, 8'hfe, 8'h00, 1'b1);
    add_step("sync_bit0_set", k_write, 6'd57, 8'h03, 8'h00, 1'b1);
    add_step("idle_hold", k_idle, 6'd57, 8'h00, 8'h00, 1'b1);
  endtask

  initial
  begin
    PRESETN     = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = 8'h00;
    period_cnt  = 8'h00;
    sync_pulse  = 1'b0;
    check_en    = 1'b0;
    done        = 1'b0;
    cur_name    = "";
    exp_prdata  = 8'h00;
    exp_cfg     = '0;
    table_ready = 1'b0;
    lcg_state   = 32'd86;
    model_reset();
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge PCLK);
    #1;
    PRESETN = 1'b1;
    foreach (steps[i])
      apply_step(i);
    done = 1'b1;
    @(posedge PCLK);
    #1;
    if (fail_cnt == 0 && pass_cnt > 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(steps.size()) * 4 * 8 * 2;
    #(limit_ns);
    $display("timeout: the stimulus table did not finish within %0d ns", limit_ns);
    $display("test failed");
    $finish;
  end

endmodule

// ==== pwm_reg_if.f ====
hw/pwm_reg_pkg.sv
hw/pwm_stage_regs.sv
hw/pwm_shadow_regs.sv
hw/pwm_read_mux.sv
hw/pwm_reg_if.sv
testbench/pwm_reg_checker.sv
testbench/tb_pwm_reg_if.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for the pass line

set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_pwm_reg_if \
  -f pwm_reg_if.f \
  -o sim_tb > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$build_log"
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$sim_log"; then
  exit 0
else
  exit 1
fi
